/* id_stage.f */
src/mips_isa_pkg.sv
src/id_ctrl_pkg.sv
src/fetch_latch.sv
src/inst_decoder.sv
src/operand_fetch.sv
src/branch_unit.sv
src/id_stage.sv
verif/id_stage_tb.sv

/* src/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  br_kind_t br_kind,
    input  word_t    id_pc,
    input  word_t    inst,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output logic     br_taken,
    output word_t    br_target
);

    word_t pc_plus4;  // delay slot address
    word_t br_offset;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  rs_zero;

    assign pc_plus4  = id_pc + 32'd4;
    assign br_offset = {{14{inst[imm_w-1]}}, inst[imm_w-1:0], 2'b00};
    assign rs_eq_rt  = (rs_data == rt_data);
    assign rs_neg    = rs_data[31];
    assign rs_zero   = (rs_data == '0);

    always_comb begin
        case (br_kind)
            br_eq:       br_taken = rs_eq_rt;
            br_ne:       br_taken = !rs_eq_rt;
            br_gez:      br_taken = !rs_neg;
            br_gtz:      br_taken = !rs_neg && !rs_zero;
            br_lez:      br_taken = rs_neg || rs_zero;
            br_ltz:      br_taken = rs_neg;
            br_jump_imm: br_taken = 1'b1;
            br_jump_reg: br_taken = 1'b1;
            default:     br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            br_jump_imm: br_target = {pc_plus4[31:28], inst[index_w-1:0], 2'b00};
            br_jump_reg: br_target = rs_data;
            default:     br_target = pc_plus4 + br_offset; // pc-relative
        endcase
    end

endmodule

/* src/fetch_latch.sv */
`timescale 1ns/1ps

module fetch_latch import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [stall_w-1:0] stall,
    input  logic               if_valid,
    input  word_t              if_pc,
    input  word_t              inst_rdata,
    output logic               id_valid,
    output word_t              id_pc,
    output word_t              inst
);

    logic  inst_held; // buffer holds the word of the stalled instruction
    word_t inst_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid  <= 1'b0;
            id_pc     <= '0;
            inst_held <= 1'b0;
            inst_buf  <= '0;
        end else if (stall[stall_id] && !stall[stall_ex]) begin
            // decode stalls, execute moves on: insert a bubble
            id_valid  <= 1'b0;
            id_pc     <= '0;
            inst_held <= 1'b0;
        end else if (!stall[stall_id]) begin
            id_valid  <= if_valid;
            id_pc     <= if_pc;
            inst_held <= 1'b0;
        end else if (!inst_held) begin
            // both stalled, memory word would be lost on the next fetch
            inst_held <= 1'b1;
            inst_buf  <= inst_rdata;
        end
    end

    // zero word is the nop
    assign inst = !id_valid  ? '0       :
                  inst_held  ? inst_buf : inst_rdata;

endmodule

/* src/id_ctrl_pkg.sv */
package id_ctrl_pkg;

    // pipeline stall vector, one bit per stage
    localparam int stall_w  = 6;
    localparam int stall_id = 1;
    localparam int stall_ex = 2;

    // one-hot alu operation, add in the top bit
    typedef logic [11:0] alu_op_t;

    localparam alu_op_t alu_add  = 12'h800;
    localparam alu_op_t alu_sub  = 12'h400;
    localparam alu_op_t alu_slt  = 12'h200;
    localparam alu_op_t alu_sltu = 12'h100;
    localparam alu_op_t alu_and  = 12'h080;
    localparam alu_op_t alu_nor  = 12'h040;
    localparam alu_op_t alu_or   = 12'h020;
    localparam alu_op_t alu_xor  = 12'h010;
    localparam alu_op_t alu_sll  = 12'h008;
    localparam alu_op_t alu_srl  = 12'h004;
    localparam alu_op_t alu_sra  = 12'h002;
    localparam alu_op_t alu_lui  = 12'h001;

    // first alu operand
    typedef logic [2:0] src1_sel_t;

    localparam src1_sel_t src1_rs = 3'b001;
    localparam src1_sel_t src1_pc = 3'b010;
    localparam src1_sel_t src1_sa = 3'b100;

    // second alu operand
    typedef logic [3:0] src2_sel_t;

    localparam src2_sel_t src2_rt    = 4'b0001;
    localparam src2_sel_t src2_simm  = 4'b0010;
    localparam src2_sel_t src2_eight = 4'b0100; // return address offset for links
    localparam src2_sel_t src2_zimm  = 4'b1000;

    typedef enum logic [3:0] {
        br_none,
        br_eq,
        br_ne,
        br_gez,
        br_gtz,
        br_lez,
        br_ltz,
        br_jump_imm,
        br_jump_reg
    } br_kind_t;

endpackage

/* src/id_stage.sv */
`timescale 1ns/1ps

module id_stage import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [stall_w-1:0] stall,
    input  logic               if_valid,
    input  word_t              if_pc,
    input  word_t              inst_rdata,
    input  logic               ex_we,
    input  reg_addr_t          ex_waddr,
    input  word_t              ex_wdata,
    input  logic               mem_we,
    input  reg_addr_t          mem_waddr,
    input  word_t              mem_wdata,
    input  logic               wb_we,
    input  reg_addr_t          wb_waddr,
    input  word_t              wb_wdata,
    input  logic               ex_is_load,
    output word_t              id_pc,
    output word_t              inst,
    output alu_op_t            alu_op,
    output src1_sel_t          src1_sel,
    output src2_sel_t          src2_sel,
    output logic               rf_we,
    output reg_addr_t          rf_waddr,
    output logic               mem_en,
    output logic [3:0]         mem_wen,
    output logic               load_res,
    output word_t              rs_data,
    output word_t              rt_data,
    output logic               br_taken,
    output word_t              br_target,
    output logic               stall_req
);

    logic     id_valid; // inst is already zeroed when this is low
    br_kind_t br_kind;

    fetch_latch fetch_latch_inst (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .inst_rdata (inst_rdata),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .inst       (inst)
    );

    inst_decoder inst_decoder_inst (
        .inst     (inst),
        .alu_op   (alu_op),
        .src1_sel (src1_sel),
        .src2_sel (src2_sel),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .mem_en   (mem_en),
        .mem_wen  (mem_wen),
        .load_res (load_res),
        .br_kind  (br_kind)
    );

    // same instruction word as the decoder
    operand_fetch operand_fetch_inst (
        .clk        (clk),
        .rst        (rst),
        .rs         (inst[rs_pos +: 5]),
        .rt         (inst[rt_pos +: 5]),
        .ex_we      (ex_we),
        .ex_waddr   (ex_waddr),
        .ex_wdata   (ex_wdata),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .ex_is_load (ex_is_load && id_valid),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .stall_req  (stall_req)
    );

    branch_unit branch_unit_inst (
        .br_kind   (br_kind),
        .id_pc     (id_pc),
        .inst      (inst),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  word_t     inst,
    output alu_op_t   alu_op,
    output src1_sel_t src1_sel,
    output src2_sel_t src2_sel,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output logic      mem_en,
    output logic [3:0] mem_wen,
    output logic      load_res,
    output br_kind_t  br_kind
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       sa_shift; // shift amount from the sa field
    logic       link;     // jal or jalr

    assign opcode   = inst[op_pos +: 6];
    assign funct    = inst[fn_pos +: 6];
    assign rt       = inst[rt_pos +: 5];
    assign rd       = inst[rd_pos +: 5];
    assign sa_shift = funct inside {fn_sll, fn_srl, fn_sra};
    assign link     = (opcode == op_jal) || (opcode == op_special && funct == fn_jalr);

    always_comb begin
        alu_op   = '0;
        src1_sel = '0;
        src2_sel = '0;
        rf_we    = 1'b0;
        rf_waddr = '0;
        mem_en   = 1'b0;
        mem_wen  = 4'b0000;
        load_res = 1'b0;
        br_kind  = br_none;

        // all-zero word is a bubble, nothing to do
        if (inst != '0) begin
            case (opcode)
                op_special: begin
                    case (funct)
                        fn_addu:          alu_op = alu_add;
                        fn_subu:          alu_op = alu_sub;
                        fn_slt:           alu_op = alu_slt;
                        fn_sltu:          alu_op = alu_sltu;
                        fn_and:           alu_op = alu_and;
                        fn_nor:           alu_op = alu_nor;
                        fn_or:            alu_op = alu_or;
                        fn_xor:           alu_op = alu_xor;
                        fn_sll, fn_sllv:  alu_op = alu_sll;
                        fn_srl, fn_srlv:  alu_op = alu_srl;
                        fn_sra, fn_srav:  alu_op = alu_sra;
                        fn_jr, fn_jalr:   br_kind = br_jump_reg;
                        default:          alu_op = '0;
                    endcase
                    if (alu_op != '0) begin // register form, result to rd
                        src1_sel = sa_shift ? src1_sa : src1_rs;
                        src2_sel = src2_rt;
                        rf_we    = 1'b1;
                        rf_waddr = rd;
                    end
                end
                op_regimm: begin
                    case (rt)
                        rt_bltz: br_kind = br_ltz;
                        rt_bgez: br_kind = br_gez;
                        default: br_kind = br_none;
                    endcase
                end
                op_addiu, op_lw, op_sw: alu_op = alu_add;
                op_slti:  alu_op = alu_slt;
                op_sltiu: alu_op = alu_sltu;
                op_andi:  alu_op = alu_and;
                op_ori:   alu_op = alu_or;
                op_xori:  alu_op = alu_xor;
                op_lui:   alu_op = alu_lui;
                op_beq:   br_kind = br_eq;
                op_bne:   br_kind = br_ne;
                op_blez:  br_kind = br_lez;
                op_bgtz:  br_kind = br_gtz;
                op_j, op_jal: br_kind = br_jump_imm;
                default:  br_kind = br_none;
            endcase

            // immediate forms, loads and stores
            if (opcode != op_special && alu_op != '0) begin
                src1_sel = (opcode == op_lui) ? '0 : src1_rs;
                src2_sel = (opcode inside {op_andi, op_ori, op_xori}) ? src2_zimm : src2_simm;
                rf_we    = (opcode != op_sw);
                rf_waddr = rt;
                mem_en   = (opcode == op_lw) || (opcode == op_sw);
                mem_wen  = {4{opcode == op_sw}};
                load_res = (opcode == op_lw);
            end

            if (link) begin // pc + 8 into r31
                alu_op   = alu_add;
                src1_sel = src1_pc;
                src2_sel = src2_eight;
                rf_we    = 1'b1;
                rf_waddr = ra_reg;
            end
        end
    end

endmodule

/* src/mips_isa_pkg.sv */
package mips_isa_pkg;

    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  reg_addr_t; // general register number

    localparam int reg_count = 32;
    localparam reg_addr_t ra_reg = 5'd31; // link register for jal and jalr

    // field positions inside the instruction word
    localparam int op_pos  = 26;
    localparam int rs_pos  = 21;
    localparam int rt_pos  = 16;
    localparam int rd_pos  = 11;
    localparam int fn_pos  = 0;
    localparam int imm_w   = 16;
    localparam int index_w = 26;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // regimm rt codes
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

endpackage

/* src/operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch import mips_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      ex_we,
    input  reg_addr_t ex_waddr,
    input  word_t     ex_wdata,
    input  logic      mem_we,
    input  reg_addr_t mem_waddr,
    input  word_t     mem_wdata,
    input  logic      wb_we,
    input  reg_addr_t wb_waddr,
    input  word_t     wb_wdata,
    input  logic      ex_is_load,
    output word_t     rs_data,
    output word_t     rt_data,
    output logic      stall_req
);

    word_t regs [reg_count];

    // writeback port, r0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    // youngest write wins
    function automatic word_t fwd(input reg_addr_t addr, input word_t rf_val);
        if (addr == '0) begin
            return '0;
        end
        if (ex_we && ex_waddr == addr) begin
            return ex_wdata;
        end
        if (mem_we && mem_waddr == addr) begin
            return mem_wdata;
        end
        if (wb_we && wb_waddr == addr) begin
            return wb_wdata; // also covers write and read in the same cycle
        end
        return rf_val;
    endfunction

    always_comb begin
        rs_data = fwd(rs, regs[rs]);
        rt_data = fwd(rt, regs[rt]);
    end

    // load result not ready until memory stage
    assign stall_req = ex_is_load && ex_we && (ex_waddr == rs || ex_waddr == rt);

endmodule

/* verif/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb import mips_isa_pkg::*, id_ctrl_pkg::*; ();

    typedef struct packed {
        word_t              inst;
        word_t              pc;
        logic [2:0]         fwd;   // ex, mem, wb write enables
        reg_addr_t          faddr; // one address for all three forwarded writes
        logic               ld;
        logic [stall_w-1:0] stl;
        alu_op_t            alu;
        src1_sel_t          s1;
        src2_sel_t          s2;
        logic               we;
        reg_addr_t          wa;
        logic [5:0]         mem;   // mem_en, mem_wen, load_res
        br_kind_t           bk;
    } row_t;

    logic               clk = 1'b0;
    logic               rst;
    logic [stall_w-1:0] stall;
    logic               if_valid;
    word_t              if_pc;
    word_t              inst_rdata;
    logic               ex_we;
    reg_addr_t          ex_waddr;
    word_t              ex_wdata;
    logic               mem_we;
    reg_addr_t          mem_waddr;
    word_t              mem_wdata;
    logic               wb_we;
    reg_addr_t          wb_waddr;
    word_t              wb_wdata;
    logic               ex_is_load;
    word_t              id_pc;
    word_t              inst;
    alu_op_t            alu_op;
    src1_sel_t          src1_sel;
    src2_sel_t          src2_sel;
    logic               rf_we;
    reg_addr_t          rf_waddr;
    logic               mem_en;
    logic [3:0]         mem_wen;
    logic               load_res;
    word_t              rs_data;
    word_t              rt_data;
    logic               br_taken;
    word_t              br_target;
    logic               stall_req;

    row_t        rows[$];
    word_t       shadow[32];  // register file copy
    logic [31:0] lfsr = 32'hb645;
    word_t       ex_d;
    word_t       mem_d;
    word_t       wb_d;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cur_row = 0;
    logic        rows_built = 1'b0;
    logic [2:0]  nxt_fwd = '0;
    reg_addr_t   nxt_faddr = '0;
    logic        nxt_ld = 1'b0;
    logic [5:0]  nxt_stl = '0;
    logic [5:0]  nxt_mem = '0;

    id_stage id_stage_inst (.*);

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word();
        word_t w = '0;
        for (int k = 0; k < 32; k++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    function automatic word_t enc_r(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                    reg_addr_t rd, logic [4:0] sa);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(logic [5:0] op, logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic set_fwd(logic [2:0] f, reg_addr_t a, logic ld);
        nxt_fwd   = f;
        nxt_faddr = a;
        nxt_ld    = ld;
    endtask

    task automatic set_stall(logic [5:0] s);
        nxt_stl = s;
    endtask

    task automatic set_mem(logic [5:0] m);
        nxt_mem = m;
    endtask

    task automatic add_row(word_t ins, alu_op_t alu, src1_sel_t s1, src2_sel_t s2,
                           logic we, reg_addr_t wa, br_kind_t bk);
        row_t r;
        r = '{ins, 32'hbfc0_0000 + 32'h40 * rows.size(), nxt_fwd, nxt_faddr, nxt_ld,
              nxt_stl, alu, s1, s2, we, wa, nxt_mem, bk};
        rows.push_back(r);
        set_fwd(3'b000, 0, 1'b0);
        set_stall('0);
        set_mem('0);
    endtask

    task automatic build_table();
        add_row(enc_r(fn_addu, 1, 2, 3, 0), alu_add, src1_rs, src2_rt, 1, 3, br_none);
        add_row(enc_r(fn_subu, 4, 5, 6, 0), alu_sub, src1_rs, src2_rt, 1, 6, br_none);
        add_row(enc_r(fn_and, 7, 8, 9, 0), alu_and, src1_rs, src2_rt, 1, 9, br_none);
        add_row(enc_r(fn_or, 10, 11, 12, 0), alu_or, src1_rs, src2_rt, 1, 12, br_none);
        add_row(enc_r(fn_xor, 13, 14, 15, 0), alu_xor, src1_rs, src2_rt, 1, 15, br_none);
        add_row(enc_r(fn_nor, 16, 17, 18, 0), alu_nor, src1_rs, src2_rt, 1, 18, br_none);
        add_row(enc_r(fn_slt, 19, 20, 21, 0), alu_slt, src1_rs, src2_rt, 1, 21, br_none);
        add_row(enc_r(fn_sltu, 22, 23, 24, 0), alu_sltu, src1_rs, src2_rt, 1, 24, br_none);
        add_row(enc_i(op_addiu, 25, 26, 16'h8001), alu_add, src1_rs, src2_simm, 1, 26, br_none);
        add_row(enc_i(op_slti, 27, 28, 16'hfff0), alu_slt, src1_rs, src2_simm, 1, 28, br_none);
        add_row(enc_i(op_sltiu, 29, 30, 16'h0007), alu_sltu, src1_rs, src2_simm, 1, 30, br_none);
        add_row(enc_i(op_andi, 1, 2, 16'hf0f0), alu_and, src1_rs, src2_zimm, 1, 2, br_none);
        add_row(enc_i(op_ori, 3, 4, 16'h8000), alu_or, src1_rs, src2_zimm, 1, 4, br_none);
        add_row(enc_i(op_xori, 5, 6, 16'h00ff), alu_xor, src1_rs, src2_zimm, 1, 6, br_none);
        add_row(enc_i(op_lui, 0, 7, 16'h1234), alu_lui, '0, src2_simm, 1, 7, br_none);
        add_row(enc_r(fn_sll, 0, 8, 9, 5), alu_sll, src1_sa, src2_rt, 1, 9, br_none);
        add_row(enc_r(fn_srl, 0, 10, 11, 31), alu_srl, src1_sa, src2_rt, 1, 11, br_none);
        add_row(enc_r(fn_sra, 0, 12, 13, 17), alu_sra, src1_sa, src2_rt, 1, 13, br_none);
        add_row(enc_r(fn_sllv, 14, 15, 16, 0), alu_sll, src1_rs, src2_rt, 1, 16, br_none);
        add_row(enc_r(fn_srlv, 17, 18, 19, 0), alu_srl, src1_rs, src2_rt, 1, 19, br_none);
        add_row(enc_r(fn_srav, 20, 21, 22, 0), alu_sra, src1_rs, src2_rt, 1, 22, br_none);
        set_mem(6'b100001);
        add_row(enc_i(op_lw, 2, 20, 16'hfff0), alu_add, src1_rs, src2_simm, 1, 20, br_none);
        set_mem(6'b111110);
        add_row(enc_i(op_sw, 3, 21, 16'h0010), alu_add, src1_rs, src2_simm, 0, 0, br_none);
        // same register on beq so the branch is taken
        add_row(enc_i(op_beq, 5, 5, 16'h0010), '0, '0, '0, 0, 0, br_eq);
        add_row(enc_i(op_bne, 6, 7, 16'hfffc), '0, '0, '0, 0, 0, br_ne);
        add_row(enc_i(op_blez, 8, 0, 16'hff00), '0, '0, '0, 0, 0, br_lez);
        add_row(enc_i(op_bgtz, 9, 0, 16'h0100), '0, '0, '0, 0, 0, br_gtz);
        add_row(enc_i(op_regimm, 10, rt_bltz, 16'h8000), '0, '0, '0, 0, 0, br_ltz);
        add_row(enc_i(op_regimm, 11, rt_bgez, 16'h7fff), '0, '0, '0, 0, 0, br_gez);
        // zero operand separates gtz from gez and lez from ltz
        add_row(enc_i(op_bgtz, 0, 0, 16'h0040), '0, '0, '0, 0, 0, br_gtz);
        add_row(enc_i(op_blez, 0, 0, 16'hffc0), '0, '0, '0, 0, 0, br_lez);
        add_row(enc_j(op_j, 26'h3ff_ffff), '0, '0, '0, 0, 0, br_jump_imm);
        add_row(enc_j(op_jal, 26'h123_4567), alu_add, src1_pc, src2_eight, 1, 31, br_jump_imm);
        add_row(enc_r(fn_jr, 12, 0, 0, 0), '0, '0, '0, 0, 0, br_jump_reg);
        add_row(enc_r(fn_jalr, 13, 0, 31, 0), alu_add, src1_pc, src2_eight, 1, 31, br_jump_reg);
        // forwarding priority on r9 and r10
        set_fwd(3'b001, 9, 1'b0);
        add_row(enc_r(fn_addu, 9, 10, 11, 0), alu_add, src1_rs, src2_rt, 1, 11, br_none);
        set_fwd(3'b011, 9, 1'b0);
        add_row(enc_r(fn_addu, 9, 10, 11, 0), alu_add, src1_rs, src2_rt, 1, 11, br_none);
        set_fwd(3'b111, 9, 1'b0);
        add_row(enc_r(fn_addu, 9, 10, 11, 0), alu_add, src1_rs, src2_rt, 1, 11, br_none);
        set_fwd(3'b010, 10, 1'b0);
        add_row(enc_r(fn_addu, 9, 10, 11, 0), alu_add, src1_rs, src2_rt, 1, 11, br_none);
        set_fwd(3'b111, 0, 1'b0); // r0 must stay zero
        add_row(enc_r(fn_addu, 0, 10, 12, 0), alu_add, src1_rs, src2_rt, 1, 12, br_none);
        // load-use
        set_fwd(3'b100, 14, 1'b1);
        add_row(enc_r(fn_addu, 14, 15, 16, 0), alu_add, src1_rs, src2_rt, 1, 16, br_none);
        set_fwd(3'b100, 15, 1'b1);
        add_row(enc_r(fn_addu, 14, 15, 16, 0), alu_add, src1_rs, src2_rt, 1, 16, br_none);
        set_fwd(3'b100, 17, 1'b1);
        add_row(enc_r(fn_addu, 14, 15, 16, 0), alu_add, src1_rs, src2_rt, 1, 16, br_none);
        set_fwd(3'b010, 14, 1'b1);
        add_row(enc_r(fn_addu, 14, 15, 16, 0), alu_add, src1_rs, src2_rt, 1, 16, br_none);
        // stall vector
        set_stall(6'b000110);
        add_row(enc_r(fn_addu, 17, 18, 19, 0), alu_add, src1_rs, src2_rt, 1, 19, br_none);
        set_stall(6'b001110);
        add_row(enc_i(op_beq, 20, 21, 16'h0020), '0, '0, '0, 0, 0, br_eq);
        set_stall(6'b000010); // bubble with nothing decoded
        add_row(enc_r(fn_addu, 22, 23, 24, 0), '0, '0, '0, 0, 0, br_none);
    endtask

    function automatic word_t operand_ref(reg_addr_t a, row_t r);
        if (a == '0) begin
            return '0;
        end
        if (r.fwd[2] && r.faddr == a) begin
            return ex_d;
        end
        if (r.fwd[1] && r.faddr == a) begin
            return mem_d;
        end
        if (r.fwd[0] && r.faddr == a) begin
            return wb_d;
        end
        return shadow[a];
    endfunction

    function automatic logic branch_ref(br_kind_t k, word_t a, word_t b);
        case (k)
            br_eq:                    return a == b;
            br_ne:                    return a != b;
            br_gez:                   return $signed(a) >= 0;
            br_gtz:                   return $signed(a) > 0;
            br_lez:                   return $signed(a) <= 0;
            br_ltz:                   return $signed(a) < 0;
            br_jump_imm, br_jump_reg: return 1'b1;
            default:                  return 1'b0;
        endcase
    endfunction

    function automatic word_t target_ref(br_kind_t k, word_t pc, word_t ins, word_t a);
        word_t next_pc;
        word_t offset;
        next_pc = pc + 32'd4;
        offset  = {{16{ins[15]}}, ins[15:0]};
        if (k == br_jump_imm) begin
            return {next_pc[31:28], ins[25:0], 2'b00};
        end
        if (k == br_jump_reg) begin
            return a;
        end
        return next_pc + (offset << 2);
    endfunction

    task automatic check_val(string name, word_t got, word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error %s: got %h, expected %h (row %0d)", name, got, exp, cur_row);
        end
    endtask

    task automatic check_row(row_t r, logic bub);
        word_t exp_inst;
        word_t a;
        word_t b;
        logic  stl_exp;
        exp_inst = bub ? '0 : r.inst;
        a = operand_ref(exp_inst[25:21], r);
        b = operand_ref(exp_inst[20:16], r);
        stl_exp = !bub && r.ld && r.fwd[2] &&
                  (r.faddr == exp_inst[25:21] || r.faddr == exp_inst[20:16]);
        check_val("inst", inst, exp_inst);
        check_val("id_pc", id_pc, bub ? '0 : r.pc);
        check_val("alu_op", alu_op, r.alu);
        check_val("src1_sel", src1_sel, r.s1);
        check_val("src2_sel", src2_sel, r.s2);
        check_val("rf_we", rf_we, r.we);
        if (r.we) begin
            check_val("rf_waddr", rf_waddr, r.wa);
        end
        check_val("mem_en", mem_en, r.mem[5]);
        check_val("mem_wen", mem_wen, r.mem[4:1]);
        check_val("load_res", load_res, r.mem[0]);
        check_val("rs_data", rs_data, a);
        check_val("rt_data", rt_data, b);
        check_val("br_taken", br_taken, branch_ref(r.bk, a, b));
        if (r.bk != br_none) begin
            check_val("br_target", br_target, target_ref(r.bk, r.pc, r.inst, a));
        end
        check_val("stall_req", stall_req, stl_exp);
    endtask

    // 20 cycles per row plus reset and preload
    initial begin
        wait (rows_built);
        #((rows.size() * 20 + 64) * 10);
        $display("timeout: the table did not complete in the allowed time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        row_t r;
        logic bub;
        rst        = 1'b1;
        stall      = '0;
        if_valid   = 1'b0;
        if_pc      = '0;
        inst_rdata = '0;
        ex_we      = 1'b0;
        ex_waddr   = '0;
        ex_wdata   = '0;
        mem_we     = 1'b0;
        mem_waddr  = '0;
        mem_wdata  = '0;
        wb_we      = 1'b0;
        wb_waddr   = '0;
        wb_wdata   = '0;
        ex_is_load = 1'b0;
        shadow[0]  = '0;
        build_table();
        rows_built = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int i = 1; i < 32; i++) begin // preload through writeback
            @(posedge clk);
            shadow[i] = rand_word();
            wb_we    <= 1'b1;
            wb_waddr <= reg_addr_t'(i);
            wb_wdata <= shadow[i];
        end
        @(posedge clk);
        wb_we <= 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            cur_row = i;
            @(posedge clk);
            if_valid   <= 1'b1;
            if_pc      <= r.pc;
            stall      <= '0;
            inst_rdata <= '0;
            ex_we      <= 1'b0;
            mem_we     <= 1'b0;
            wb_we      <= 1'b0;
            ex_is_load <= 1'b0;
            @(posedge clk); // pc now in the fetch latch
            ex_d  = rand_word();
            mem_d = rand_word();
            wb_d  = rand_word();
            if_valid   <= 1'b0;
            inst_rdata <= r.inst;
            stall      <= r.stl;
            ex_we      <= r.fwd[2];
            ex_waddr   <= r.faddr;
            ex_wdata   <= ex_d;
            mem_we     <= r.fwd[1];
            mem_waddr  <= r.faddr;
            mem_wdata  <= mem_d;
            wb_we      <= r.fwd[0];
            wb_waddr   <= r.faddr;
            wb_wdata   <= wb_d;
            ex_is_load <= r.ld;
            bub = r.stl[stall_id] && !r.stl[stall_ex];
            if (bub) begin
                @(posedge clk);
            end else if (r.stl[stall_id]) begin
                repeat (2) begin
                    @(posedge clk);
                    inst_rdata <= rand_word(); // memory moves on
                end
            end
            #1;
            check_row(r, bub);
            if (r.fwd[0] && r.faddr != '0) begin
                shadow[r.faddr] = wb_d;
            end
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
